// ==== Makefile ====
# Verilator build and run for the writeback and commit stage

VERILATOR ?= verilator
TOP       ?= tb_writeback_commit
DUT_TOP   ?= writeback_commit_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j $(JOBS)
LINTFLAGS ?= --lint-only -Wall
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Test passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Status comes from the search for the pass line
run: build
	@out="$$(./$(SIM_BIN) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

# RTL alone, then the whole testbench
lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(DUT_TOP) \
		verilog/wb_pkg.sv verilog/writeback_arbiter.sv verilog/reorder_buffer.sv \
		verilog/arch_regfile.sv verilog/writeback_commit_top.sv
	$(VERILATOR) $(LINTFLAGS) --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== all.f ====
verilog/wb_pkg.sv
verilog/writeback_arbiter.sv
verilog/reorder_buffer.sv
verilog/arch_regfile.sv
verilog/writeback_commit_top.sv
tests/writeback_commit_properties.sv
tests/tb_writeback_commit.sv

// ==== tests/tb_writeback_commit.sv ====
//------------------------------
// Testbench for the writeback and commit stage
// 160 results in shuffled batches of rob_depth over two pipes
// A batch starts only once the previous batch is fully accepted
//------------------------------
`timescale 1ns/1ns

module tb_writeback_commit;
  import wb_pkg::*;

  localparam int num_results = 160;
  localparam int num_batches = num_results / rob_depth;
  localparam int max_cycles  = num_results * 12 + 64;

  logic clk;
  logic rst_n;
  logic [num_pipes-1:0]                     x_val;
  logic [num_pipes-1:0][seq_bits-1:0]       x_seq_num;
  logic [num_pipes-1:0][xlen-1:0]           x_pc;
  logic [num_pipes-1:0][reg_addr_bits-1:0]  x_waddr;
  logic [num_pipes-1:0][xlen-1:0]           x_wdata;
  logic [num_pipes-1:0]                     x_wen;
  logic [num_pipes-1:0]                     x_rdy;
  logic                     complete_val;
  logic [seq_bits-1:0]      complete_seq_num;
  logic [reg_addr_bits-1:0] complete_waddr;
  logic [xlen-1:0]          complete_wdata;
  logic                     complete_wen;
  logic                     commit_val;
  logic [xlen-1:0]          commit_pc;
  logic [seq_bits-1:0]      commit_seq_num;
  logic [reg_addr_bits-1:0] commit_waddr;
  logic [xlen-1:0]          commit_wdata;
  logic                     commit_wen;
  logic [reg_addr_bits-1:0] rd_addr;
  logic [xlen-1:0]          rd_data;

  //------------------------------
  // Scoreboard and stimulus state
  //------------------------------

  // Indexed by global sequence order
  logic [xlen-1:0]          sb_pc    [num_results];
  logic [reg_addr_bits-1:0] sb_waddr [num_results];
  logic [xlen-1:0]          sb_wdata [num_results];
  logic                     sb_wen   [num_results];
  logic [xlen-1:0]          exp_regs [num_regs];

  // Global index, pipe and lead-in delay of each batch item
  int item_g    [rob_depth];
  int item_pipe [rob_depth];
  int item_dly  [rob_depth];
  // Item each lane is presenting
  int lane_g [num_pipes];

  logic [31:0] rng;
  int errors;
  int commit_count;
  int complete_count;
  int cycles;
  logic exp_cval;
  int exp_g;

  writeback_commit_top uut (.*);

  always #2 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("Timeout after %0d cycles, %0d of %0d results committed",
               cycles, commit_count, num_results);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rng = rng * 32'd1664525 + 32'd1013904223;
    return rng;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("[ERROR] %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
    errors++;
  endtask

  task automatic report_failure(input string what);
    $display("Check failed at %0t ns: %s", $time, what);
    errors++;
  endtask

  // Random results with pc marking program order
  task automatic fill_scoreboard();
    logic [31:0] r;
    for (int g = 0; g < num_results; g++) begin
      r = next_rand();
      sb_pc[g]    = 32'h0000_1000 + (32'(g) << 2);
      sb_waddr[g] = r[20:16];
      sb_wen[g]   = (r[25:24] != 2'b00);
      sb_wdata[g] = next_rand();
    end
  endtask

  // Shuffled batch so pipes deliver out of order
  task automatic build_batch(input int base);
    int j;
    int tmp;
    logic [31:0] r;
    for (int k = 0; k < rob_depth; k++) begin
      item_g[k] = base + k;
    end
    for (int k = rob_depth - 1; k > 0; k--) begin
      r = next_rand();
      j = int'(r[23:16]) % (k + 1);
      tmp = item_g[k];
      item_g[k] = item_g[j];
      item_g[j] = tmp;
    end
    for (int k = 0; k < rob_depth; k++) begin
      r = next_rand();
      item_pipe[k] = int'(r[16]);
      item_dly[k]  = int'(r[19:18]);
    end
  endtask

  // Entered and left 1 ns after a rising edge
  task automatic send_lane(input int p);
    int g;
    logic took;
    for (int k = 0; k < rob_depth; k++) begin
      if (item_pipe[k] == p) begin
        g = item_g[k];
        repeat (item_dly[k]) begin
          @(posedge clk);
          #1;
        end
        lane_g[p]    = g;
        x_val[p]     = 1'b1;
        x_seq_num[p] = seq_bits'(g);
        x_pc[p]      = sb_pc[g];
        x_waddr[p]   = sb_waddr[g];
        x_wdata[p]   = sb_wdata[g];
        x_wen[p]     = sb_wen[g];
        // Hold until a transfer edge
        do begin
          @(negedge clk);
          took = x_rdy[p];
          @(posedge clk);
          #1;
        end while (!took);
        x_val[p] = 1'b0;
      end
    end
  endtask

  // Debug read of one register
  task automatic check_reg(input int a, input logic [xlen-1:0] exp);
    rd_addr = reg_addr_bits'(a);
    @(negedge clk);
    assert (rd_data == exp) else report_mismatch($sformatf("rd_data[%0d]", a), exp, rd_data);
    @(posedge clk);
    #1;
  endtask

  //------------------------------
  // Output monitor at mid-cycle
  //------------------------------

  always @(negedge clk) begin
    if (!rst_n) begin
      assert (!complete_val) else report_mismatch("complete_val", 32'd0, 32'(complete_val));
      assert (!commit_val) else report_mismatch("commit_val", 32'd0, 32'(commit_val));
      exp_cval = 1'b0;
    end else begin
      // Transfer at the previous edge shows up now
      assert (complete_val == exp_cval)
        else report_mismatch("complete_val", 32'(exp_cval), 32'(complete_val));
      if (exp_cval && complete_val) begin
        complete_count++;
        assert (complete_seq_num == seq_bits'(exp_g))
          else report_mismatch("complete_seq_num", 32'(exp_g % rob_depth),
                               32'(complete_seq_num));
        assert (complete_waddr == sb_waddr[exp_g])
          else report_mismatch("complete_waddr", 32'(sb_waddr[exp_g]), 32'(complete_waddr));
        assert (complete_wdata == sb_wdata[exp_g])
          else report_mismatch("complete_wdata", sb_wdata[exp_g], complete_wdata);
        assert (complete_wen == sb_wen[exp_g])
          else report_mismatch("complete_wen", 32'(sb_wen[exp_g]), 32'(complete_wen));
      end
      if (commit_val) begin
        if (commit_count >= num_results) begin
          report_failure("commit seen after every result had retired");
        end else begin
          assert (commit_seq_num == seq_bits'(commit_count))
            else report_mismatch("commit_seq_num", 32'(commit_count % rob_depth),
                                 32'(commit_seq_num));
          assert (commit_pc == sb_pc[commit_count])
            else report_mismatch("commit_pc", sb_pc[commit_count], commit_pc);
          assert (commit_waddr == sb_waddr[commit_count])
            else report_mismatch("commit_waddr", 32'(sb_waddr[commit_count]),
                                 32'(commit_waddr));
          assert (commit_wdata == sb_wdata[commit_count])
            else report_mismatch("commit_wdata", sb_wdata[commit_count], commit_wdata);
          assert (commit_wen == sb_wen[commit_count])
            else report_mismatch("commit_wen", 32'(sb_wen[commit_count]), 32'(commit_wen));
        end
        commit_count++;
      end
      // Lanes transferring at the coming edge
      assert ($countones(x_val & x_rdy) <= 1)
        else report_failure("two lanes transferred in the same cycle");
      exp_cval = 1'b0;
      for (int p = 0; p < num_pipes; p++) begin
        if (x_val[p] && x_rdy[p]) begin
          exp_cval = 1'b1;
          exp_g = lane_g[p];
        end
      end
    end
  end

  //------------------------------
  // Main sequence
  //------------------------------

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    // Both lanes offer a result while reset holds
    x_val = '1;
    x_seq_num = '0;
    x_pc = '0;
    x_waddr = '0;
    x_wdata = '0;
    x_wen = '0;
    rd_addr = '0;
    rng = 32'hb75a;
    errors = 0;
    commit_count = 0;
    complete_count = 0;
    cycles = 0;
    exp_cval = 1'b0;
    exp_g = 0;
    fill_scoreboard();
    repeat (12) @(posedge clk);
    #1;
    x_val = '0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Register file clear out of reset
    for (int a = 0; a < num_regs; a++) begin
      check_reg(a, '0);
    end
    for (int b = 0; b < num_batches; b++) begin
      build_batch(b * rob_depth);
      fork
        send_lane(0);
        send_lane(1);
      join
    end
    wait (commit_count == num_results);
    // Let the last write land and any stray commit show
    repeat (4) @(posedge clk);
    #1;
    // Final architectural state in program order
    for (int a = 0; a < num_regs; a++) begin
      exp_regs[a] = '0;
    end
    for (int g = 0; g < num_results; g++) begin
      if (sb_wen[g] && sb_waddr[g] != '0) begin
        exp_regs[sb_waddr[g]] = sb_wdata[g];
      end
    end
    for (int a = 0; a < num_regs; a++) begin
      check_reg(a, exp_regs[a]);
    end
    assert (commit_count == num_results)
      else report_mismatch("commit count", 32'(num_results), 32'(commit_count));
    assert (complete_count == num_results)
      else report_mismatch("completion count", 32'(num_results), 32'(complete_count));
    $display("Summary: %0d check errors, %0d property failures, %0d of %0d committed",
             errors, uut.props.fail_count, commit_count, num_results);
    if (errors == 0 && uut.props.fail_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== tests/writeback_commit_properties.sv ====
//------------------------------
// Timing and ordering properties for the writeback stage
// Bound into writeback_commit_top, sees the internal alloc path
//------------------------------
`timescale 1ns/1ns

module writeback_commit_properties (
  input logic                             clk,
  input logic                             rst_n,
  input logic [wb_pkg::num_pipes-1:0]     x_rdy,
  input logic [wb_pkg::num_pipes-1:0]     slot_free,
  input logic                             alloc_val,
  input logic [wb_pkg::seq_bits-1:0]      alloc_seq_num,
  input logic [wb_pkg::reg_addr_bits-1:0] alloc_waddr,
  input logic [wb_pkg::xlen-1:0]          alloc_wdata,
  input logic                             alloc_wen,
  input logic                             complete_val,
  input logic [wb_pkg::seq_bits-1:0]      complete_seq_num,
  input logic [wb_pkg::reg_addr_bits-1:0] complete_waddr,
  input logic [wb_pkg::xlen-1:0]          complete_wdata,
  input logic                             complete_wen,
  input logic                             commit_val,
  input logic [wb_pkg::seq_bits-1:0]      commit_seq_num
);
  import wb_pkg::*;

  // Failed property count, read by the testbench at the end
  int fail_count = 0;

  // Tag the next commit must carry
  logic [seq_bits-1:0] next_seq;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      next_seq <= '0;
    end else if (commit_val) begin
      next_seq <= next_seq + 1'b1;
    end
  end

  //------------------------------
  // Properties
  //------------------------------

  // Accepted result is announced the next cycle, fields unchanged
  a_complete_follows_alloc: assert property (@(posedge clk) disable iff (!rst_n)
    alloc_val |=> complete_val && complete_seq_num == $past(alloc_seq_num) &&
      complete_waddr == $past(alloc_waddr) && complete_wdata == $past(alloc_wdata) &&
      complete_wen == $past(alloc_wen))
    else begin
      $error("completion missing or wrong one cycle after a transfer");
      fail_count++;
    end

  // No notification without a transfer
  a_no_spurious_complete: assert property (@(posedge clk) disable iff (!rst_n)
    !alloc_val |=> !complete_val)
    else begin
      $error("complete_val raised without a transfer");
      fail_count++;
    end

  // Commit tags step by one, wrapping
  a_commit_in_order: assert property (@(posedge clk) disable iff (!rst_n)
    commit_val |-> commit_seq_num == next_seq)
    else begin
      $error("commit_seq_num skipped or repeated");
      fail_count++;
    end

  // Both notifications quiet while held in reset
  a_quiet_in_reset: assert property (@(posedge clk)
    !rst_n |=> !complete_val && !commit_val)
    else begin
      $error("notification active during reset");
      fail_count++;
    end

  // Ready never offered on an occupied slot
  a_rdy_needs_slot: assert property (@(posedge clk) disable iff (!rst_n)
    (x_rdy & ~slot_free) == '0)
    else begin
      $error("x_rdy high on a lane whose slot is occupied");
      fail_count++;
    end

  // At most one lane granted
  a_single_grant: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(x_rdy))
    else begin
      $error("more than one lane ready in one cycle");
      fail_count++;
    end

endmodule

bind writeback_commit_top writeback_commit_properties props (
  .clk              (clk),
  .rst_n            (rst_n),
  .x_rdy            (x_rdy),
  .slot_free        (slot_free),
  .alloc_val        (alloc_val),
  .alloc_seq_num    (alloc_seq_num),
  .alloc_waddr      (alloc_waddr),
  .alloc_wdata      (alloc_wdata),
  .alloc_wen        (alloc_wen),
  .complete_val     (complete_val),
  .complete_seq_num (complete_seq_num),
  .complete_waddr   (complete_waddr),
  .complete_wdata   (complete_wdata),
  .complete_wen     (complete_wen),
  .commit_val       (commit_val),
  .commit_seq_num   (commit_seq_num)
);

// ==== verilog/arch_regfile.sv ====
//------------------------------
// Architectural registers updated only by commit
// x0 is never written and reads as zero
// Debug read is combinational
//------------------------------
`timescale 1ns/1ns

module arch_regfile (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             commit_val,
  input  logic [wb_pkg::reg_addr_bits-1:0] commit_waddr,
  input  logic [wb_pkg::xlen-1:0]          commit_wdata,
  input  logic                             commit_wen,
  input  logic [wb_pkg::reg_addr_bits-1:0] rd_addr,
  output logic [wb_pkg::xlen-1:0]          rd_data
);
  import wb_pkg::*;

  // Register array
  logic [xlen-1:0] regs [num_regs];

  // Write strobe for a real destination
  logic we;

  assign we = commit_val && commit_wen && (commit_waddr != '0);

  //------------------------------
  // Write port
  //------------------------------

  // Whole file starts at zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[commit_waddr] <= commit_wdata;
    end
  end

  //------------------------------
  // Debug read
  //------------------------------

  // regs[0] stays zero since writes to it are masked
  assign rd_data = regs[rd_addr];

endmodule

// ==== verilog/reorder_buffer.sv ====
//------------------------------
// Result store indexed directly by sequence number
// Retires one entry per cycle from head, strictly in order
// Aliasing tags are held off through slot_free, never overwritten
//------------------------------
`timescale 1ns/1ns

module reorder_buffer (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic [wb_pkg::num_pipes-1:0][wb_pkg::seq_bits-1:0] x_seq_num,
  output logic [wb_pkg::num_pipes-1:0]                     slot_free,
  input  logic                                             alloc_val,
  input  logic [wb_pkg::seq_bits-1:0]                      alloc_seq_num,
  input  logic [wb_pkg::xlen-1:0]                          alloc_pc,
  input  logic [wb_pkg::reg_addr_bits-1:0]                 alloc_waddr,
  input  logic [wb_pkg::xlen-1:0]                          alloc_wdata,
  input  logic                                             alloc_wen,
  output logic                                             commit_val,
  output logic [wb_pkg::xlen-1:0]                          commit_pc,
  output logic [wb_pkg::seq_bits-1:0]                      commit_seq_num,
  output logic [wb_pkg::reg_addr_bits-1:0]                 commit_waddr,
  output logic [wb_pkg::xlen-1:0]                          commit_wdata,
  output logic                                             commit_wen
);
  import wb_pkg::*;

  //------------------------------
  // Storage
  //------------------------------

  // Slot holds a result waiting to retire
  logic [rob_depth-1:0] occupied;

  // Entry payload
  // The tag itself is the slot index so it is not stored
  logic [xlen-1:0]          ent_pc    [rob_depth];
  logic [reg_addr_bits-1:0] ent_waddr [rob_depth];
  logic [xlen-1:0]          ent_wdata [rob_depth];
  logic                     ent_wen   [rob_depth];

  // Oldest sequence number not yet retired
  logic [seq_bits-1:0] head;

  // Head slot can retire this cycle
  logic head_ready;

  assign head_ready = occupied[head];

  //------------------------------
  // Slot lookup per pipe
  //------------------------------

  // Empty slot for each pipe's requested tag
  // Uses registered state, so a slot freed at an edge opens the cycle after
  always_comb begin
    for (int i = 0; i < num_pipes; i++) begin
      slot_free[i] = !occupied[x_seq_num[i]];
    end
  end

  //------------------------------
  // Occupancy and head pointer
  //------------------------------

  // Allocation only targets an empty slot and retire only an occupied one,
  // so the two never touch the same bit at one edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      occupied   <= '0;
      head       <= '0;
      commit_val <= 1'b0;
    end else begin
      commit_val <= head_ready;
      if (head_ready) begin
        occupied[head] <= 1'b0;
        // Natural wrap since depth is a power of two
        head <= head + 1'b1;
      end
      if (alloc_val) begin
        occupied[alloc_seq_num] <= 1'b1;
      end
    end
  end

  //------------------------------
  // Entry write
  //------------------------------

  // Payload lands in its slot at the accepting edge
  always_ff @(posedge clk) begin
    if (alloc_val) begin
      ent_pc[alloc_seq_num]    <= alloc_pc;
      ent_waddr[alloc_seq_num] <= alloc_waddr;
      ent_wdata[alloc_seq_num] <= alloc_wdata;
      ent_wen[alloc_seq_num]   <= alloc_wen;
    end
  end

  //------------------------------
  // Commit outputs
  //------------------------------

  // Registered copy of the head entry
  // Valid one cycle after head is seen full
  always_ff @(posedge clk) begin
    if (head_ready) begin
      commit_pc      <= ent_pc[head];
      commit_seq_num <= head;
      commit_waddr   <= ent_waddr[head];
      commit_wdata   <= ent_wdata[head];
      commit_wen     <= ent_wen[head];
    end
  end

endmodule

// ==== verilog/wb_pkg.sv ====
//------------------------------
// Widths and depths for the writeback and commit stage
// rob_depth must stay a power of two so sequence numbers wrap freely
//------------------------------
package wb_pkg;

  //------------------------------
  // Execute side
  //------------------------------

  // Execute pipes feeding writeback
  localparam int num_pipes = 2;

  // Width of the sequence tag carried with every result
  localparam int seq_bits = 3;

  //------------------------------
  // Reorder buffer
  //------------------------------

  // One slot per sequence number
  // Tags alias modulo this depth
  localparam int rob_depth = 1 << seq_bits;

  //------------------------------
  // Datapath and register file
  //------------------------------

  // PC and data width
  localparam int xlen = 32;

  // Register address width
  localparam int reg_addr_bits = 5;

  // Architectural registers, x0 included
  localparam int num_regs = 32;

endpackage

// ==== verilog/writeback_arbiter.sv ====
//------------------------------
// Round-robin pick of one execute pipe per cycle
// A lane is only granted when its reorder slot is free
// x_rdy depends on x_val and the lane's sequence number
//------------------------------
`timescale 1ns/1ns

module writeback_arbiter (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic [wb_pkg::num_pipes-1:0]                     x_val,
  input  logic [wb_pkg::num_pipes-1:0][wb_pkg::seq_bits-1:0] x_seq_num,
  input  logic [wb_pkg::num_pipes-1:0][wb_pkg::xlen-1:0]   x_pc,
  input  logic [wb_pkg::num_pipes-1:0][wb_pkg::reg_addr_bits-1:0] x_waddr,
  input  logic [wb_pkg::num_pipes-1:0][wb_pkg::xlen-1:0]   x_wdata,
  input  logic [wb_pkg::num_pipes-1:0]                     x_wen,
  output logic [wb_pkg::num_pipes-1:0]                     x_rdy,
  input  logic [wb_pkg::num_pipes-1:0]                     slot_free,
  output logic                                             alloc_val,
  output logic [wb_pkg::seq_bits-1:0]                      alloc_seq_num,
  output logic [wb_pkg::xlen-1:0]                          alloc_pc,
  output logic [wb_pkg::reg_addr_bits-1:0]                 alloc_waddr,
  output logic [wb_pkg::xlen-1:0]                          alloc_wdata,
  output logic                                             alloc_wen,
  output logic                                             complete_val,
  output logic [wb_pkg::seq_bits-1:0]                      complete_seq_num,
  output logic [wb_pkg::reg_addr_bits-1:0]                 complete_waddr,
  output logic [wb_pkg::xlen-1:0]                          complete_wdata,
  output logic                                             complete_wen
);
  import wb_pkg::*;

  // Lanes able to transfer this cycle
  logic [num_pipes-1:0] req;
  // One-hot grant and the one-hot lane that won last
  logic [num_pipes-1:0] grant;
  logic [num_pipes-1:0] last_grant;
  logic                 found;

  assign req = x_val & slot_free;

  //------------------------------
  // Round-robin search
  //------------------------------

  // Walk lanes starting just after last winner
  always_comb begin
    grant = '0;
    found = 1'b0;
    for (int off = 1; off <= num_pipes; off++) begin
      for (int i = 0; i < num_pipes; i++) begin
        if (last_grant[i] && !found && req[(i + off) % num_pipes]) begin
          grant[(i + off) % num_pipes] = 1'b1;
          found = 1'b1;
        end
      end
    end
  end

  // Ready only on the winning lane
  assign x_rdy     = grant;
  assign alloc_val = found;

  // Forward the winning lane's fields
  always_comb begin
    alloc_seq_num = '0;
    alloc_pc      = '0;
    alloc_waddr   = '0;
    alloc_wdata   = '0;
    alloc_wen     = 1'b0;
    for (int i = 0; i < num_pipes; i++) begin
      if (grant[i]) begin
        alloc_seq_num = x_seq_num[i];
        alloc_pc      = x_pc[i];
        alloc_waddr   = x_waddr[i];
        alloc_wdata   = x_wdata[i];
        alloc_wen     = x_wen[i];
      end
    end
  end

  //------------------------------
  // Pointer and completion
  //------------------------------

  // Start with the top lane as last winner so lane 0 goes first
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_grant <= '0;
      last_grant[num_pipes-1] <= 1'b1;
      complete_val <= 1'b0;
    end else begin
      if (found) begin
        last_grant <= grant;
      end
      // One-cycle pulse per accepted result
      complete_val <= found;
    end
  end

  // Completion payload
  always_ff @(posedge clk) begin
    if (found) begin
      complete_seq_num <= alloc_seq_num;
      complete_waddr   <= alloc_waddr;
      complete_wdata   <= alloc_wdata;
      complete_wen     <= alloc_wen;
    end
  end

endmodule

// ==== verilog/writeback_commit_top.sv ====
//------------------------------
// Writeback and commit stage of the integer core
// At most rob_depth results in flight, tags wrap modulo rob_depth
//------------------------------
`timescale 1ns/1ns

module writeback_commit_top (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic [wb_pkg::num_pipes-1:0]                     x_val,
  input  logic [wb_pkg::num_pipes-1:0][wb_pkg::seq_bits-1:0] x_seq_num,
  input  logic [wb_pkg::num_pipes-1:0][wb_pkg::xlen-1:0]   x_pc,
  input  logic [wb_pkg::num_pipes-1:0][wb_pkg::reg_addr_bits-1:0] x_waddr,
  input  logic [wb_pkg::num_pipes-1:0][wb_pkg::xlen-1:0]   x_wdata,
  input  logic [wb_pkg::num_pipes-1:0]                     x_wen,
  output logic [wb_pkg::num_pipes-1:0]                     x_rdy,
  output logic                                             complete_val,
  output logic [wb_pkg::seq_bits-1:0]                      complete_seq_num,
  output logic [wb_pkg::reg_addr_bits-1:0]                 complete_waddr,
  output logic [wb_pkg::xlen-1:0]                          complete_wdata,
  output logic                                             complete_wen,
  output logic                                             commit_val,
  output logic [wb_pkg::xlen-1:0]                          commit_pc,
  output logic [wb_pkg::seq_bits-1:0]                      commit_seq_num,
  output logic [wb_pkg::reg_addr_bits-1:0]                 commit_waddr,
  output logic [wb_pkg::xlen-1:0]                          commit_wdata,
  output logic                                             commit_wen,
  input  logic [wb_pkg::reg_addr_bits-1:0]                 rd_addr,
  output logic [wb_pkg::xlen-1:0]                          rd_data
);
  import wb_pkg::*;

  //------------------------------
  // Arbiter to reorder buffer
  //------------------------------

  logic [num_pipes-1:0]     slot_free;
  logic                     alloc_val;
  logic [seq_bits-1:0]      alloc_seq_num;
  logic [xlen-1:0]          alloc_pc;
  logic [reg_addr_bits-1:0] alloc_waddr;
  logic [xlen-1:0]          alloc_wdata;
  logic                     alloc_wen;

  // Lane selection and completion notice
  writeback_arbiter u_arbiter (
    .clk              (clk),
    .rst_n            (rst_n),
    .x_val            (x_val),
    .x_seq_num        (x_seq_num),
    .x_pc             (x_pc),
    .x_waddr          (x_waddr),
    .x_wdata          (x_wdata),
    .x_wen            (x_wen),
    .x_rdy            (x_rdy),
    .slot_free        (slot_free),
    .alloc_val        (alloc_val),
    .alloc_seq_num    (alloc_seq_num),
    .alloc_pc         (alloc_pc),
    .alloc_waddr      (alloc_waddr),
    .alloc_wdata      (alloc_wdata),
    .alloc_wen        (alloc_wen),
    .complete_val     (complete_val),
    .complete_seq_num (complete_seq_num),
    .complete_waddr   (complete_waddr),
    .complete_wdata   (complete_wdata),
    .complete_wen     (complete_wen)
  );

  // In-order retire
  reorder_buffer u_rob (
    .clk            (clk),
    .rst_n          (rst_n),
    .x_seq_num      (x_seq_num),
    .slot_free      (slot_free),
    .alloc_val      (alloc_val),
    .alloc_seq_num  (alloc_seq_num),
    .alloc_pc       (alloc_pc),
    .alloc_waddr    (alloc_waddr),
    .alloc_wdata    (alloc_wdata),
    .alloc_wen      (alloc_wen),
    .commit_val     (commit_val),
    .commit_pc      (commit_pc),
    .commit_seq_num (commit_seq_num),
    .commit_waddr   (commit_waddr),
    .commit_wdata   (commit_wdata),
    .commit_wen     (commit_wen)
  );

  // Commit steers the register file
  arch_regfile u_regfile (
    .clk          (clk),
    .rst_n        (rst_n),
    .commit_val   (commit_val),
    .commit_waddr (commit_waddr),
    .commit_wdata (commit_wdata),
    .commit_wen   (commit_wen),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data)
  );

endmodule
